/* hdl/cpu_pkg.sv */
package cpu_pkg;

	typedef logic [31:0] uint32_t;
	typedef logic [4:0]  reg_addr_t;

	localparam uint32_t RESET_PC = 32'h0000_0000;

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;
	localparam logic [5:0] OP_LB      = 6'b100000;
	localparam logic [5:0] OP_LW      = 6'b100011;
	localparam logic [5:0] OP_LBU     = 6'b100100;
	localparam logic [5:0] OP_SB      = 6'b101000;
	localparam logic [5:0] OP_SW      = 6'b101011;

	// SPECIAL function field
	localparam logic [5:0] FN_SLL   = 6'b000000;
	localparam logic [5:0] FN_SRL   = 6'b000010;
	localparam logic [5:0] FN_SRA   = 6'b000011;
	localparam logic [5:0] FN_MFHI  = 6'b010000;
	localparam logic [5:0] FN_MFLO  = 6'b010010;
	localparam logic [5:0] FN_MULTU = 6'b011001;
	localparam logic [5:0] FN_ADDU  = 6'b100001;
	localparam logic [5:0] FN_SUBU  = 6'b100011;
	localparam logic [5:0] FN_AND   = 6'b100100;
	localparam logic [5:0] FN_OR    = 6'b100101;
	localparam logic [5:0] FN_XOR   = 6'b100110;
	localparam logic [5:0] FN_SLT   = 6'b101010;
	localparam logic [5:0] FN_SLTU  = 6'b101011;

	typedef enum logic [3:0] {
		ALU_NONE, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_MFHI, ALU_MFLO, ALU_MULTU
	} alu_op_t;

	typedef enum logic [2:0] {
		MEM_NONE, MEM_LW, MEM_LB, MEM_LBU, MEM_SW, MEM_SB
	} mem_op_t;

	typedef enum logic [1:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_J
	} branch_t;

	typedef struct packed {
		uint32_t   pc;
		alu_op_t   alu_op;
		mem_op_t   mem_op;
		branch_t   branch;
		uint32_t   op_a;
		uint32_t   op_b;
		uint32_t   store_data;
		uint32_t   imm_target;
		reg_addr_t rd;
		logic      valid;
	} decode_t;

	typedef struct packed {
		uint32_t   result;
		uint32_t   store_data;
		mem_op_t   mem_op;
		reg_addr_t rd;
		logic      valid;
	} exmem_t;

endpackage

/* hdl/regfile.sv */
module regfile
	import cpu_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  reg_addr_t [1:0] raddr,
	output uint32_t   [1:0] rdata,
	input  logic            we,
	input  reg_addr_t       waddr,
	input  uint32_t         wdata
);

uint32_t regs [32];

// r0 is never written, so reset keeps it at zero
always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < 32; i++) begin
			regs[i] <= '0;
		end
	end else if (we && waddr != '0) begin
		regs[waddr] <= wdata;
	end
end

// write-first bypass
always_comb begin
	for (int i = 0; i < 2; i++) begin
		if (raddr[i] == '0) begin
			rdata[i] = '0;
		end else if (we && waddr == raddr[i]) begin
			rdata[i] = wdata;
		end else begin
			rdata[i] = regs[raddr[i]];
		end
	end
end

endmodule

/* hdl/instr_fetch.sv */
module instr_fetch
	import cpu_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    stall,
	input  logic    flush,
	input  uint32_t branch_target,
	output logic    ibus_read,
	output uint32_t ibus_addr,
	input  uint32_t ibus_rddata,
	input  logic    ibus_stall,
	output uint32_t fetch_pc,
	output uint32_t fetch_instr,
	output logic    fetch_valid
);

uint32_t pc;
uint32_t redirect_pc;
logic    redirect_pend;
logic    drop_pend;
logic    fetch_done;

// the same word is simply fetched again while the stage is held
assign ibus_read  = 1'b1;
assign ibus_addr  = pc;
assign fetch_done = ibus_read & ~ibus_stall;

always_ff @(posedge clk) begin
	if (rst) begin
		pc            <= RESET_PC;
		fetch_valid   <= 1'b0;
		redirect_pend <= 1'b0;
		drop_pend     <= 1'b0;
	end else if (~stall) begin
		if (flush && fetch_valid) begin
			// delay slot already in decode, drop the word on the bus
			fetch_valid <= 1'b0;
			if (fetch_done) begin
				pc <= branch_target;
			end else begin
				// address stays put until that access ends
				drop_pend     <= 1'b1;
				redirect_pend <= 1'b1;
			end
		end else if (fetch_done) begin
			fetch_valid   <= ~drop_pend;
			drop_pend     <= 1'b0;
			redirect_pend <= 1'b0;
			if (flush) begin
				pc <= branch_target;
			end else if (redirect_pend) begin
				pc <= redirect_pc;
			end else begin
				pc <= pc + 32'd4;
			end
		end else begin
			fetch_valid <= 1'b0;
			// delay slot still on its way
			if (flush) begin
				redirect_pend <= 1'b1;
			end
		end
	end
end

always_ff @(posedge clk) begin
	if (~stall && fetch_done) begin
		fetch_pc    <= pc;
		fetch_instr <= ibus_rddata;
	end
	if (~stall && flush) begin
		redirect_pc <= branch_target;
	end
end

endmodule

/* hdl/decode_and_issue.sv */
module decode_and_issue
	import cpu_pkg::*;
(
	input  uint32_t         fetch_pc,
	input  uint32_t         fetch_instr,
	input  logic            fetch_valid,
	output reg_addr_t [1:0] raddr,
	input  uint32_t   [1:0] rdata,
	input  exmem_t          ex_fwd,
	input  reg_addr_t       mem_rd,
	input  uint32_t         mem_data,
	output decode_t         decoded,
	output reg_addr_t       src_rs,
	output reg_addr_t       src_rt
);

logic [5:0] opcode;
logic [5:0] funct;
reg_addr_t  rs;
reg_addr_t  rt;
reg_addr_t  rd;
uint32_t    imm_sext;
uint32_t    imm_zext;
uint32_t    shamt;
uint32_t    pc_next;
uint32_t    rs_val;
uint32_t    rt_val;

assign opcode   = fetch_instr[31:26];
assign rs       = fetch_instr[25:21];
assign rt       = fetch_instr[20:16];
assign rd       = fetch_instr[15:11];
assign funct    = fetch_instr[5:0];
assign imm_sext = {{16{fetch_instr[15]}}, fetch_instr[15:0]};
assign imm_zext = {16'h0, fetch_instr[15:0]};
assign shamt    = {27'h0, fetch_instr[10:6]};
assign pc_next  = fetch_pc + 32'd4;

assign raddr[0] = rs;
assign raddr[1] = rt;

// newest producer wins: execute, then memory, then register file
function automatic uint32_t fwd(reg_addr_t src, uint32_t reg_val, exmem_t ex,
	reg_addr_t wb_src, uint32_t wb_val);
	if (src == '0) begin
		return '0;
	end else if (ex.valid && ex.rd == src) begin
		return ex.result;
	end else if (wb_src == src) begin
		return wb_val;
	end
	return reg_val;
endfunction

assign rs_val = fwd(rs, rdata[0], ex_fwd, mem_rd, mem_data);
assign rt_val = fwd(rt, rdata[1], ex_fwd, mem_rd, mem_data);

always_comb begin
	decoded            = '0;
	src_rs             = '0;
	src_rt             = '0;
	decoded.pc         = fetch_pc;
	decoded.op_a       = rs_val;
	decoded.op_b       = rt_val;
	decoded.store_data = rt_val;
	decoded.imm_target = pc_next + {imm_sext[29:0], 2'b00};
	decoded.valid      = fetch_valid;
	if (fetch_valid) begin
		case (opcode)
			OP_SPECIAL: begin
				src_rs     = rs;
				src_rt     = rt;
				decoded.rd = rd;
				case (funct)
					FN_ADDU: decoded.alu_op = ALU_ADD;
					FN_SUBU: decoded.alu_op = ALU_SUB;
					FN_AND:  decoded.alu_op = ALU_AND;
					FN_OR:   decoded.alu_op = ALU_OR;
					FN_XOR:  decoded.alu_op = ALU_XOR;
					FN_SLT:  decoded.alu_op = ALU_SLT;
					FN_SLTU: decoded.alu_op = ALU_SLTU;
					FN_SLL, FN_SRL, FN_SRA: begin
						// shift amount travels in op_a
						src_rs         = '0;
						decoded.op_a   = shamt;
						decoded.alu_op = funct == FN_SLL ? ALU_SLL :
							funct == FN_SRL ? ALU_SRL : ALU_SRA;
					end
					FN_MULTU: begin
						decoded.alu_op = ALU_MULTU;
						decoded.rd     = '0;
					end
					FN_MFHI, FN_MFLO: begin
						src_rs         = '0;
						src_rt         = '0;
						decoded.alu_op = funct == FN_MFHI ? ALU_MFHI : ALU_MFLO;
					end
					default: begin
						src_rs     = '0;
						src_rt     = '0;
						decoded.rd = '0;
					end
				endcase
			end
			OP_J: begin
				decoded.branch     = BR_J;
				decoded.imm_target = {pc_next[31:28], fetch_instr[25:0], 2'b00};
			end
			OP_BEQ, OP_BNE: begin
				src_rs         = rs;
				src_rt         = rt;
				decoded.branch = opcode == OP_BEQ ? BR_BEQ : BR_BNE;
			end
			OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				src_rs       = opcode == OP_LUI ? reg_addr_t'(0) : rs;
				decoded.rd   = rt;
				decoded.op_b = imm_sext;
				case (opcode)
					OP_ADDIU: decoded.alu_op = ALU_ADD;
					OP_SLTI:  decoded.alu_op = ALU_SLT;
					OP_ANDI:  decoded.alu_op = ALU_AND;
					OP_ORI:   decoded.alu_op = ALU_OR;
					OP_XORI:  decoded.alu_op = ALU_XOR;
					default:  decoded.alu_op = ALU_LUI;
				endcase
				if (opcode == OP_ANDI || opcode == OP_ORI || opcode == OP_XORI) begin
					decoded.op_b = imm_zext;
				end
			end
			OP_LW, OP_LB, OP_LBU: begin
				src_rs         = rs;
				decoded.rd     = rt;
				decoded.op_b   = imm_sext;
				decoded.alu_op = ALU_ADD;
				decoded.mem_op = opcode == OP_LW ? MEM_LW :
					opcode == OP_LB ? MEM_LB : MEM_LBU;
			end
			OP_SW, OP_SB: begin
				src_rs         = rs;
				src_rt         = rt;
				decoded.op_b   = imm_sext;
				decoded.alu_op = ALU_ADD;
				decoded.mem_op = opcode == OP_SW ? MEM_SW : MEM_SB;
			end
			default: begin
				// unsupported opcode runs as a no-op
				decoded.rd = '0;
			end
		endcase
	end
end

endmodule

/* hdl/instr_exec.sv */
module instr_exec
	import cpu_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    stall,
	input  decode_t data,
	output exmem_t  result,
	output logic    branch_taken,
	output uint32_t branch_target
);

uint32_t     hi;
uint32_t     lo;
uint32_t     alu_out;
logic [63:0] product;
logic        operands_equal;

assign product        = 64'(data.op_a) * 64'(data.op_b);
assign operands_equal = data.op_a == data.op_b;

always_comb begin
	case (data.alu_op)
		ALU_ADD:  alu_out = data.op_a + data.op_b;
		ALU_SUB:  alu_out = data.op_a - data.op_b;
		ALU_AND:  alu_out = data.op_a & data.op_b;
		ALU_OR:   alu_out = data.op_a | data.op_b;
		ALU_XOR:  alu_out = data.op_a ^ data.op_b;
		ALU_SLT:  alu_out = {31'h0, $signed(data.op_a) < $signed(data.op_b)};
		ALU_SLTU: alu_out = {31'h0, data.op_a < data.op_b};
		// shifts take the amount from op_a, the value from op_b
		ALU_SLL:  alu_out = data.op_b << data.op_a[4:0];
		ALU_SRL:  alu_out = data.op_b >> data.op_a[4:0];
		ALU_SRA:  alu_out = $signed(data.op_b) >>> data.op_a[4:0];
		ALU_LUI:  alu_out = {data.op_b[15:0], 16'h0};
		ALU_MFHI: alu_out = hi;
		ALU_MFLO: alu_out = lo;
		default:  alu_out = '0;
	endcase
end

always_ff @(posedge clk) begin
	if (rst) begin
		hi <= '0;
		lo <= '0;
	end else if (~stall && data.valid && data.alu_op == ALU_MULTU) begin
		{hi, lo} <= product;
	end
end

always_comb begin
	result.result     = alu_out;
	result.store_data = data.store_data;
	result.mem_op     = data.mem_op;
	result.rd         = data.rd;
	result.valid      = data.valid;
end

always_comb begin
	case (data.branch)
		BR_BEQ:  branch_taken = data.valid & operands_equal;
		BR_BNE:  branch_taken = data.valid & ~operands_equal;
		BR_J:    branch_taken = data.valid;
		default: branch_taken = 1'b0;
	endcase
end

// target was already formed in decode
assign branch_target = data.imm_target;

endmodule

/* hdl/instr_mem.sv */
module instr_mem
	import cpu_pkg::*;
(
	input  exmem_t    data,
	output logic      dbus_read,
	output logic      dbus_write,
	output uint32_t   dbus_addr,
	output logic [3:0] dbus_byteenable,
	output uint32_t   dbus_wdata,
	input  uint32_t   dbus_rddata,
	output reg_addr_t wb_rd,
	output uint32_t   wb_data
);

logic       is_load;
logic       is_store;
logic       is_byte;
logic [1:0] lane;
logic [7:0] load_byte;

assign is_load  = data.mem_op == MEM_LW || data.mem_op == MEM_LB || data.mem_op == MEM_LBU;
assign is_store = data.mem_op == MEM_SW || data.mem_op == MEM_SB;
assign is_byte  = data.mem_op == MEM_LB || data.mem_op == MEM_LBU || data.mem_op == MEM_SB;
assign lane     = data.result[1:0];

assign dbus_read  = data.valid & is_load;
assign dbus_write = data.valid & is_store;
assign dbus_addr  = {data.result[31:2], 2'b00};

assign dbus_byteenable = is_byte ? 4'b0001 << lane : 4'b1111;

// byte stores go out on every lane
assign dbus_wdata = data.mem_op == MEM_SB ? {4{data.store_data[7:0]}} : data.store_data;

assign load_byte = dbus_rddata[8 * lane +: 8];

always_comb begin
	case (data.mem_op)
		MEM_LW:  wb_data = dbus_rddata;
		MEM_LB:  wb_data = {{24{load_byte[7]}}, load_byte};
		MEM_LBU: wb_data = {24'h0, load_byte};
		default: wb_data = data.result;
	endcase
end

assign wb_rd = data.valid ? data.rd : '0;

endmodule

/* hdl/ctrl.sv */
module ctrl
	import cpu_pkg::*;
(
	input  mem_op_t   ex_mem_op,
	input  reg_addr_t ex_rd,
	input  reg_addr_t src_rs,
	input  reg_addr_t src_rt,
	input  logic      branch_taken,
	input  logic      dbus_stall,
	output logic      stall_if,
	output logic      stall_id,
	output logic      stall_all,
	output logic      flush_if
);

logic ex_is_load;
logic load_use;

assign ex_is_load = ex_mem_op == MEM_LW || ex_mem_op == MEM_LB || ex_mem_op == MEM_LBU;

// load result only exists after the memory stage
assign load_use = ex_is_load && ex_rd != '0 && (ex_rd == src_rs || ex_rd == src_rt);

assign stall_all = dbus_stall;
assign stall_id  = load_use;
assign stall_if  = load_use | dbus_stall;

// a held branch redirects once the pipeline moves again
assign flush_if = branch_taken & ~dbus_stall;

endmodule

/* hdl/cpu_core.sv */
module cpu_core
	import cpu_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic [5:0] intr,
	output logic       ibus_read,
	output uint32_t    ibus_addr,
	input  uint32_t    ibus_rddata,
	input  logic       ibus_stall,
	output logic       dbus_read,
	output logic       dbus_write,
	output uint32_t    dbus_addr,
	output logic [3:0] dbus_byteenable,
	output uint32_t    dbus_wdata,
	input  uint32_t    dbus_rddata,
	input  logic       dbus_stall
);

// pipeline control
logic stall_if;
logic stall_id;
logic stall_all;
logic flush_if;

// register file
reg_addr_t [1:0] reg_raddr;
uint32_t   [1:0] reg_rdata;

// fetch to decode
uint32_t fetch_pc;
uint32_t fetch_instr;
logic    fetch_valid;

// stage records
decode_t   id_decoded;
decode_t   idex;
exmem_t    exec_result;
exmem_t    exmem;
reg_addr_t id_src_rs;
reg_addr_t id_src_rt;
logic      branch_taken;
uint32_t   branch_target;
reg_addr_t wb_rd;
uint32_t   wb_data;

ctrl ctrl_inst(
	.ex_mem_op    ( idex.mem_op  ),
	.ex_rd        ( idex.rd      ),
	.src_rs       ( id_src_rs    ),
	.src_rt       ( id_src_rt    ),
	.branch_taken,
	.dbus_stall,
	.stall_if,
	.stall_id,
	.stall_all,
	.flush_if
);

// no write while a load waits on the data bus
regfile regfile_inst(
	.clk,
	.rst,
	.raddr ( reg_raddr  ),
	.rdata ( reg_rdata  ),
	.we    ( ~stall_all ),
	.waddr ( wb_rd      ),
	.wdata ( wb_data    )
);

instr_fetch instr_fetch_inst(
	.clk,
	.rst,
	.stall ( stall_if ),
	.flush ( flush_if ),
	.branch_target,
	.ibus_read,
	.ibus_addr,
	.ibus_rddata,
	.ibus_stall,
	.fetch_pc,
	.fetch_instr,
	.fetch_valid
);

decode_and_issue decode_issue_inst(
	.fetch_pc,
	.fetch_instr,
	.fetch_valid,
	.raddr    ( reg_raddr   ),
	.rdata    ( reg_rdata   ),
	.ex_fwd   ( exec_result ),
	.mem_rd   ( wb_rd       ),
	.mem_data ( wb_data     ),
	.decoded  ( id_decoded  ),
	.src_rs   ( id_src_rs   ),
	.src_rt   ( id_src_rt   )
);

// ID/EX, bubble on load-use
always_ff @(posedge clk) begin
	if (rst || (stall_id && ~stall_all)) begin
		idex <= '0;
	end else if (~stall_all) begin
		idex <= id_decoded;
	end
end

instr_exec exec_inst(
	.clk,
	.rst,
	.stall  ( stall_all   ),
	.data   ( idex        ),
	.result ( exec_result ),
	.branch_taken,
	.branch_target
);

// EX/MEM
always_ff @(posedge clk) begin
	if (rst) begin
		exmem <= '0;
	end else if (~stall_all) begin
		exmem <= exec_result;
	end
end

instr_mem mem_inst(
	.data ( exmem ),
	.dbus_read,
	.dbus_write,
	.dbus_addr,
	.dbus_byteenable,
	.dbus_wdata,
	.dbus_rddata,
	.wb_rd,
	.wb_data
);

endmodule

/* bench/tb_mem.sv */
module tb_mem (
	input  logic        clk,
	input  logic        rst,
	input  logic        ibus_read,
	input  logic [31:0] ibus_addr,
	output logic [31:0] ibus_rddata,
	output logic        ibus_stall,
	input  logic        dbus_read,
	input  logic        dbus_write,
	input  logic [31:0] dbus_addr,
	input  logic [3:0]  dbus_byteenable,
	input  logic [31:0] dbus_wdata,
	output logic [31:0] dbus_rddata,
	output logic        dbus_stall
);

localparam int DEPTH = 1024;

logic [31:0] words [DEPTH];
logic [31:0] log_addr [$];
logic [3:0]  log_be [$];
logic [31:0] log_data [$];
integer      seed;
logic [31:0] rnd;
logic        ihold;
logic        dhold;

// fill word carries its own byte address
initial begin
	seed = 32'hb096acc1;
	for (int i = 0; i < DEPTH; i++) begin
		words[i] = 32'h5a00_0000 ^ (i * 4);
	end
end

assign ibus_rddata = words[ibus_addr[11:2]];
// load data only while a read is requested
assign dbus_rddata = dbus_read ? words[dbus_addr[11:2]] : 'x;
assign ibus_stall  = ibus_read & ihold;
assign dbus_stall  = (dbus_read | dbus_write) & dhold;

always @(posedge clk) begin
	rnd = $random(seed);
	if (rst) begin
		ihold <= 1'b0;
		dhold <= 1'b0;
	end else begin
		ihold <= rnd[0] & rnd[1];
		dhold <= rnd[2] & rnd[3];
	end
	// store completes when not held
	if (!rst && dbus_write && !dbus_stall) begin
		for (int b = 0; b < 4; b++) begin
			if (dbus_byteenable[b]) begin
				words[dbus_addr[11:2]][8 * b +: 8] <= dbus_wdata[8 * b +: 8];
			end
		end
		log_addr.push_back(dbus_addr);
		log_be.push_back(dbus_byteenable);
		log_data.push_back(dbus_wdata);
	end
end

task load_word(input int idx, input logic [31:0] w);
	words[idx] = w;
endtask

endmodule

/* bench/tb_cpu_core.sv */
module tb_cpu_core
	import cpu_pkg::*;
();

localparam int TIMEOUT = 20000;
localparam logic [31:0] END_ADDR = 32'h0000_07f0;

logic        clk;
logic        rst;
logic [5:0]  intr;
logic        ibus_read;
logic [31:0] ibus_addr;
logic [31:0] ibus_rddata;
logic        ibus_stall;
logic        dbus_read;
logic        dbus_write;
logic [31:0] dbus_addr;
logic [3:0]  dbus_byteenable;
logic [31:0] dbus_wdata;
logic [31:0] dbus_rddata;
logic        dbus_stall;

logic [31:0] prog [$];
logic [31:0] exp_addr [$];
logic [3:0]  exp_be [$];
logic [31:0] exp_data [$];
int          mismatches;
int          other_errors;
int          cycles;
logic        done;

cpu_core i_dut (.*);

tb_mem i_mem (.*);

initial begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

function automatic logic [31:0] r_word(int rs, int rt, int rd, int sh, logic [5:0] fn);
	return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
endfunction

function automatic logic [31:0] i_word(logic [5:0] op, int rs, int rt, int imm);
	return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic logic [31:0] j_word(int idx);
	return {OP_J, 26'(idx)};
endfunction

task automatic expect_store(logic [31:0] a, logic [3:0] be, logic [31:0] d);
	exp_addr.push_back(a);
	exp_be.push_back(be);
	exp_data.push_back(d);
endtask

task automatic build_program();
	// dependent alu chain, base pointer in r10
	prog.push_back(i_word(OP_ADDIU, 0, 10, 'h400));
	prog.push_back(i_word(OP_ADDIU, 0, 1, 5));
	prog.push_back(i_word(OP_ADDIU, 1, 2, 7));
	prog.push_back(r_word(1, 2, 3, 0, FN_ADDU));
	prog.push_back(r_word(3, 1, 4, 0, FN_SUBU));
	prog.push_back(i_word(OP_SW, 10, 3, 0));
	prog.push_back(i_word(OP_SW, 10, 4, 4));
	prog.push_back(i_word(OP_LUI, 0, 5, 'h8000));
	prog.push_back(i_word(OP_ORI, 5, 5, 'h00f0));
	prog.push_back(r_word(5, 3, 6, 0, FN_XOR));
	prog.push_back(r_word(0, 5, 7, 4, FN_SRA));
	prog.push_back(r_word(0, 5, 8, 4, FN_SRL));
	prog.push_back(r_word(0, 5, 9, 1, FN_SLL));
	prog.push_back(r_word(5, 1, 11, 0, FN_SLT));
	prog.push_back(r_word(5, 1, 12, 0, FN_SLTU));
	prog.push_back(r_word(7, 8, 13, 0, FN_AND));
	prog.push_back(i_word(OP_SW, 10, 6, 8));
	prog.push_back(i_word(OP_SW, 10, 7, 12));
	prog.push_back(i_word(OP_SW, 10, 8, 16));
	prog.push_back(i_word(OP_SW, 10, 9, 20));
	prog.push_back(i_word(OP_SW, 10, 11, 24));
	prog.push_back(i_word(OP_SW, 10, 12, 28));
	prog.push_back(i_word(OP_SW, 10, 13, 32));
	prog.push_back(i_word(OP_XORI, 13, 14, 'hffff));
	prog.push_back(i_word(OP_ANDI, 14, 15, 'h0ff0));
	prog.push_back(i_word(OP_SLTI, 5, 16, -1));
	prog.push_back(i_word(OP_SW, 10, 14, 36));
	prog.push_back(i_word(OP_SW, 10, 15, 40));
	prog.push_back(i_word(OP_SW, 10, 16, 44));
	// load-use, then byte loads and stores on every lane
	prog.push_back(i_word(OP_LW, 10, 17, 0));
	prog.push_back(i_word(OP_ADDIU, 17, 18, 1));
	prog.push_back(i_word(OP_SW, 10, 18, 48));
	prog.push_back(i_word(OP_LUI, 0, 19, 'h80ff));
	prog.push_back(i_word(OP_ORI, 19, 19, 'h7f01));
	prog.push_back(i_word(OP_SW, 10, 19, 52));
	prog.push_back(i_word(OP_LB, 10, 20, 52));
	prog.push_back(i_word(OP_LB, 10, 21, 53));
	prog.push_back(i_word(OP_LB, 10, 22, 54));
	prog.push_back(i_word(OP_LBU, 10, 23, 55));
	prog.push_back(i_word(OP_LBU, 10, 24, 54));
	prog.push_back(i_word(OP_SB, 10, 22, 56));
	prog.push_back(i_word(OP_SB, 10, 21, 57));
	prog.push_back(i_word(OP_SB, 10, 23, 58));
	prog.push_back(i_word(OP_SB, 10, 20, 59));
	prog.push_back(i_word(OP_LW, 10, 25, 56));
	prog.push_back(i_word(OP_SW, 10, 25, 60));
	prog.push_back(i_word(OP_SW, 10, 24, 64));
	// taken beq at word 47, skipped path stores to 0x47c
	prog.push_back(i_word(OP_BEQ, 1, 1, 3));
	prog.push_back(i_word(OP_ADDIU, 0, 26, 'h11));
	prog.push_back(i_word(OP_SW, 10, 1, 'h7c));
	prog.push_back(i_word(OP_SW, 10, 1, 'h7c));
	prog.push_back(i_word(OP_SW, 10, 26, 68));
	prog.push_back(i_word(OP_BNE, 1, 1, 2));
	prog.push_back(i_word(OP_ADDIU, 0, 27, 'h22));
	prog.push_back(i_word(OP_ADDIU, 27, 27, 'h100));
	prog.push_back(i_word(OP_SW, 10, 27, 72));
	prog.push_back(j_word(59));
	prog.push_back(i_word(OP_ADDIU, 0, 28, 'h33));
	prog.push_back(i_word(OP_SW, 10, 1, 'h7c));
	prog.push_back(i_word(OP_SW, 10, 28, 76));
	prog.push_back(r_word(5, 13, 0, 0, FN_MULTU));
	prog.push_back(r_word(0, 0, 30, 0, FN_MFHI));
	prog.push_back(r_word(0, 0, 31, 0, FN_MFLO));
	prog.push_back(i_word(OP_SW, 10, 30, 80));
	prog.push_back(i_word(OP_SW, 10, 31, 84));
	prog.push_back(i_word(OP_SW, 0, 1, END_ADDR));
	prog.push_back(j_word(66));
	prog.push_back(32'h0);
endtask

task automatic queue_expected_stores();
	expect_store(32'h400, 4'hf, 32'h0000_0011);
	expect_store(32'h404, 4'hf, 32'h0000_000c);
	expect_store(32'h408, 4'hf, 32'h8000_00e1);
	expect_store(32'h40c, 4'hf, 32'hf800_000f);
	expect_store(32'h410, 4'hf, 32'h0800_000f);
	expect_store(32'h414, 4'hf, 32'h0000_01e0);
	expect_store(32'h418, 4'hf, 32'h0000_0001);
	expect_store(32'h41c, 4'hf, 32'h0000_0000);
	expect_store(32'h420, 4'hf, 32'h0800_000f);
	expect_store(32'h424, 4'hf, 32'h0800_fff0);
	expect_store(32'h428, 4'hf, 32'h0000_0ff0);
	expect_store(32'h42c, 4'hf, 32'h0000_0001);
	expect_store(32'h430, 4'hf, 32'h0000_0012);
	expect_store(32'h434, 4'hf, 32'h80ff_7f01);
	// byte stores show the byte on every lane
	expect_store(32'h438, 4'h1, 32'hffff_ffff);
	expect_store(32'h438, 4'h2, 32'h7f7f_7f7f);
	expect_store(32'h438, 4'h4, 32'h8080_8080);
	expect_store(32'h438, 4'h8, 32'h0101_0101);
	expect_store(32'h43c, 4'hf, 32'h0180_7fff);
	expect_store(32'h440, 4'hf, 32'h0000_00ff);
	expect_store(32'h444, 4'hf, 32'h0000_0011);
	expect_store(32'h448, 4'hf, 32'h0000_0122);
	expect_store(32'h44c, 4'hf, 32'h0000_0033);
	// 0x800000f0 * 0x0800000f
	expect_store(32'h450, 4'hf, 32'h0400_000f);
	expect_store(32'h454, 4'hf, 32'h0000_0e10);
	expect_store(END_ADDR, 4'hf, 32'h0000_0005);
endtask

// no store before the first one of the program
always @(negedge clk) begin
	if (i_mem.log_addr.size() == 0) begin
		assert (!dbus_write || dbus_addr == 32'h400) else begin
			$display("early store on dbus at %h", dbus_addr);
			other_errors++;
		end
	end
end

initial begin
	mismatches   = 0;
	other_errors = 0;
	done         = 1'b0;
	rst  <= 1'b1;
	intr <= '0;
	build_program();
	queue_expected_stores();
	@(posedge clk);
	for (int i = 0; i < prog.size(); i++) begin
		i_mem.load_word(i, prog[i]);
	end
	repeat (4) @(posedge clk);
	rst <= 1'b0;
	@(negedge clk);
	assert (ibus_read && ibus_addr == RESET_PC) else begin
		$display("Mismatch ibus_addr: got %h expected %h", ibus_addr, RESET_PC);
		mismatches++;
	end
	assert (!dbus_read && !dbus_write) else begin
		$display("data bus request active right after reset");
		other_errors++;
	end
	cycles = 0;
	while (!done && cycles < TIMEOUT) begin
		@(negedge clk);
		cycles++;
		if (i_mem.log_addr.size() > 0) begin
			done = i_mem.log_addr[i_mem.log_addr.size() - 1] == END_ADDR;
		end
	end
	if (!done) begin
		$display("timeout waiting for the end marker store");
		other_errors++;
	end
	assert (i_mem.log_addr.size() == exp_addr.size()) else begin
		$display("Mismatch store count: got %h expected %h",
			i_mem.log_addr.size(), exp_addr.size());
		mismatches++;
	end
	for (int k = 0; k < exp_addr.size() && k < i_mem.log_addr.size(); k++) begin
		assert (i_mem.log_addr[k] == exp_addr[k]) else begin
			$display("Mismatch dbus_addr store %0d: got %h expected %h",
				k, i_mem.log_addr[k], exp_addr[k]);
			mismatches++;
		end
		assert (i_mem.log_be[k] == exp_be[k]) else begin
			$display("Mismatch dbus_byteenable store %0d: got %h expected %h",
				k, i_mem.log_be[k], exp_be[k]);
			mismatches++;
		end
		assert (i_mem.log_data[k] == exp_data[k]) else begin
			$display("Mismatch dbus_wdata store %0d: got %h expected %h",
				k, i_mem.log_data[k], exp_data[k]);
			mismatches++;
		end
	end
	$display("errors: %0d mismatches, %0d other", mismatches, other_errors);
	if (mismatches == 0 && other_errors == 0) begin
		$display(">>> PASS");
	end else begin
		$display(">>> FAIL");
	end
	$finish;
end

endmodule

/* src.f */
hdl/cpu_pkg.sv
hdl/regfile.sv
hdl/instr_fetch.sv
hdl/decode_and_issue.sv
hdl/instr_exec.sv
hdl/instr_mem.sv
hdl/ctrl.sv
hdl/cpu_core.sv
bench/tb_mem.sv
bench/tb_cpu_core.sv
